//--- mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Fetch address loaded by reset.
`define MIPS_RESET_VECTOR 32'hBFC00000

// Register written by JAL, BGEZAL and BLTZAL.
`define MIPS_LINK_REG 5'd31

`define MIPS_NUM_REGS 32

`endif

//--- mips_pkg.sv
package mips_pkg;

    typedef enum logic [6:0] {
        NOP    = 7'd0,
        ADDU   = 7'd1,
        SUBU   = 7'd2,
        AND_OP = 7'd3,
        OR_OP  = 7'd4,
        SLT    = 7'd5,
        ADDIU  = 7'd6,
        ANDI   = 7'd7,
        ORI    = 7'd8,
        LUI    = 7'd9,
        BEQ    = 7'd30,
        BGEZ   = 7'd31,
        BGEZAL = 7'd32,
        BGTZ   = 7'd33,
        BLEZ   = 7'd34,
        BLTZ   = 7'd35,
        BLTZAL = 7'd36,
        BNE    = 7'd37,
        J      = 7'd38,
        JAL    = 7'd39,
        JALR   = 7'd40,
        JR     = 7'd41
    } instr_code_t;

    typedef enum logic [1:0] {
        FETCH,
        EXEC1,
        EXEC2,
        HALT
    } phase_t;

    typedef struct packed {
        instr_code_t code;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dest;
        logic [15:0] imm;         // Also the branch offset.
        logic [25:0] instr_index;
        logic        writes;
        logic        use_imm;
        logic        cmp_zero;    // Compare rs against zero, not rt.
    } decoded_t;

    typedef struct packed {
        logic zero;
        logic positive;
        logic negative;
    } flags_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  addr;
        logic [31:0] data;
    } wb_t;

endpackage

//--- cycle_control.sv
module cycle_control (
    input  logic clk,
    input  logic reset,
    input  logic pc_halt,
    output logic fetch,
    output logic exec1,
    output logic exec2
);
    import mips_pkg::*;

    phase_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            case (state)
                FETCH: begin
                    if (pc_halt) begin
                        state <= HALT;  // Stays here until reset.
                    end else begin
                        state <= EXEC1;
                    end
                end
                EXEC1:   state <= EXEC2;
                EXEC2:   state <= FETCH;
                default: state <= HALT;
            endcase
        end
    end

    assign fetch = (state == FETCH);
    assign exec1 = (state == EXEC1);
    assign exec2 = (state == EXEC2);

endmodule

//--- program_counter.sv
`include "mips_config.svh"

module program_counter (
    input  logic               clk,
    input  logic               reset,
    input  logic               fetch,
    input  mips_pkg::decoded_t dec,
    input  logic [31:0]        register_data,
    input  mips_pkg::flags_t   flags,
    output logic [31:0]        address,
    output logic               pc_halt
);
    import mips_pkg::*;

    logic [31:0] branch_target;
    logic [31:0] jump_address;
    logic [31:0] jump_address_reg;
    logic        jump;
    logic        jump_flag;

    // Address already points at the delay slot.
    assign branch_target = address + {{14{dec.imm[15]}}, dec.imm, 2'b00};
    assign pc_halt = (address == 32'd0);

    always_comb begin
        jump = 1'b0;
        jump_address = branch_target;
        case (dec.code)
            BEQ:          jump = flags.zero;
            BNE:          jump = flags.positive | flags.negative;
            BGTZ:         jump = flags.positive;
            BLEZ:         jump = flags.zero | flags.negative;
            BGEZ, BGEZAL: jump = flags.positive | flags.zero;
            BLTZ, BLTZAL: jump = flags.negative;
            J, JAL: begin
                jump = 1'b1;
                jump_address = {address[31:28], dec.instr_index, 2'b00};
            end
            JR, JALR: begin
                jump = 1'b1;
                jump_address = register_data;
            end
            default: jump = 1'b0;
        endcase
    end

    // The record is sampled through the exec phases; the exec2 sample,
    // taken after the flags settle, is the one the next fetch applies.
    always_ff @(posedge clk) begin
        if (reset) begin
            address <= `MIPS_RESET_VECTOR;
            jump_flag <= 1'b0;
        end else if (fetch) begin
            if (pc_halt) begin
                address <= 32'd0;
            end else if (jump_flag) begin
                address <= jump_address_reg;
            end else begin
                address <= address + 32'd4;
            end
            jump_flag <= 1'b0;
        end else begin
            jump_flag <= jump;
        end
    end

    always_ff @(posedge clk) begin
        if (!fetch) begin
            jump_address_reg <= jump_address;
        end
    end

endmodule

//--- instr_decoder.sv
`include "mips_config.svh"

module instr_decoder (
    input  logic               clk,
    input  logic               reset,
    input  logic               fetch,
    input  logic [31:0]        instr_data,
    output mips_pkg::decoded_t dec
);
    import mips_pkg::*;

    logic [31:0] ir;
    logic [5:0]  opcode;
    logic [5:0]  funct;
    instr_code_t code;

    assign opcode = ir[31:26];
    assign funct = ir[5:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= 32'd0;  // Encodes NOP.
        end else if (fetch) begin
            ir <= instr_data;
        end
    end

    always_comb begin
        code = NOP;
        case (opcode)
            6'h00: begin
                case (funct)
                    6'h08:   code = JR;
                    6'h09:   code = JALR;
                    6'h21:   code = ADDU;
                    6'h23:   code = SUBU;
                    6'h24:   code = AND_OP;
                    6'h25:   code = OR_OP;
                    6'h2A:   code = SLT;
                    default: code = NOP;
                endcase
            end
            6'h01: begin  // REGIMM picks the condition by rt.
                case (ir[20:16])
                    5'h00:   code = BLTZ;
                    5'h01:   code = BGEZ;
                    5'h10:   code = BLTZAL;
                    5'h11:   code = BGEZAL;
                    default: code = NOP;
                endcase
            end
            6'h02:   code = J;
            6'h03:   code = JAL;
            6'h04:   code = BEQ;
            6'h05:   code = BNE;
            6'h06:   code = BLEZ;
            6'h07:   code = BGTZ;
            6'h09:   code = ADDIU;
            6'h0C:   code = ANDI;
            6'h0D:   code = ORI;
            6'h0F:   code = LUI;
            default: code = NOP;
        endcase
    end

    always_comb begin
        dec.code = code;
        dec.rs = ir[25:21];
        dec.rt = ir[20:16];
        dec.imm = ir[15:0];
        dec.instr_index = ir[25:0];
        dec.dest = ir[15:11];
        dec.writes = code inside {ADDU, SUBU, AND_OP, OR_OP, SLT, JALR,
                                  ADDIU, ANDI, ORI, LUI, JAL, BGEZAL, BLTZAL};
        dec.use_imm = code inside {ADDIU, ANDI, ORI, LUI};
        dec.cmp_zero = code inside {BGEZ, BGEZAL, BGTZ, BLEZ, BLTZ, BLTZAL};
        if (dec.use_imm) begin
            dec.dest = ir[20:16];
        end else if (code inside {JAL, BGEZAL, BLTZAL}) begin
            dec.dest = `MIPS_LINK_REG;  // Link written even if not taken.
        end
    end

endmodule

//--- register_file.sv
`include "mips_config.svh"

module register_file (
    input  logic          clk,
    input  logic          reset,
    input  logic [4:0]    rs,
    input  logic [4:0]    rt,
    input  mips_pkg::wb_t wb,
    output logic [31:0]   rs_data,
    output logic [31:0]   rt_data
);
    logic [31:0] regs [`MIPS_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wb.we && (wb.addr != 5'd0)) begin
            regs[wb.addr] <= wb.data;  // r0 never written.
        end
    end

    assign rs_data = (rs == 5'd0) ? 32'd0 : regs[rs];
    assign rt_data = (rt == 5'd0) ? 32'd0 : regs[rt];

endmodule

//--- alu.sv
module alu (
    input  logic               clk,
    input  logic               reset,
    input  logic               exec1,
    input  mips_pkg::decoded_t dec,
    input  logic [31:0]        rs_data,
    input  logic [31:0]        rt_data,
    input  logic [31:0]        address,
    output logic [31:0]        result,
    output mips_pkg::flags_t   flags
);
    import mips_pkg::*;

    logic [31:0] operand_b;
    logic [31:0] alu_out;
    logic [31:0] cmp_value;

    always_comb begin
        if (!dec.use_imm) begin
            operand_b = rt_data;
        end else if (dec.code == ADDIU) begin
            operand_b = {{16{dec.imm[15]}}, dec.imm};
        end else begin
            operand_b = {16'd0, dec.imm};  // ANDI and ORI zero-extend.
        end
    end

    always_comb begin
        case (dec.code)
            ADDU, ADDIU: alu_out = rs_data + operand_b;
            SUBU:        alu_out = rs_data - operand_b;
            AND_OP, ANDI: alu_out = rs_data & operand_b;
            OR_OP, ORI:  alu_out = rs_data | operand_b;
            SLT:         alu_out = {31'd0, $signed(rs_data) < $signed(operand_b)};
            LUI:         alu_out = {dec.imm, 16'd0};
            JAL, JALR, BGEZAL, BLTZAL: alu_out = address + 32'd4;  // Branch plus 8.
            default:     alu_out = 32'd0;
        endcase
    end

    assign cmp_value = dec.cmp_zero ? rs_data : rs_data - rt_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            flags <= '0;
        end else if (exec1) begin
            flags.zero <= (cmp_value == 32'd0);
            flags.positive <= (cmp_value != 32'd0) && !cmp_value[31];
            flags.negative <= cmp_value[31];
        end
    end

    always_ff @(posedge clk) begin
        if (exec1) begin
            result <= alu_out;
        end
    end

endmodule

//--- mips_core.sv
module mips_core (
    input  logic          clk,
    input  logic          reset,
    input  logic [31:0]   instr_data,
    output logic [31:0]   address,
    output mips_pkg::wb_t wb,
    output logic          halted
);
    import mips_pkg::*;

    logic        fetch;
    logic        exec1;
    logic        exec2;
    logic        pc_halt;
    decoded_t    dec;
    flags_t      flags;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] result;

    assign wb = '{we: exec2 & dec.writes, addr: dec.dest, data: result};
    assign halted = pc_halt;

    cycle_control u_cycle_control (
        .clk     (clk),
        .reset   (reset),
        .pc_halt (pc_halt),
        .fetch   (fetch),
        .exec1   (exec1),
        .exec2   (exec2)
    );

    program_counter u_program_counter (
        .clk           (clk),
        .reset         (reset),
        .fetch         (fetch),
        .dec           (dec),
        .register_data (rs_data),
        .flags         (flags),
        .address       (address),
        .pc_halt       (pc_halt)
    );

    instr_decoder u_instr_decoder (
        .clk        (clk),
        .reset      (reset),
        .fetch      (fetch),
        .instr_data (instr_data),
        .dec        (dec)
    );

    register_file u_register_file (
        .clk     (clk),
        .reset   (reset),
        .rs      (dec.rs),
        .rt      (dec.rt),
        .wb      (wb),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    alu u_alu (
        .clk     (clk),
        .reset   (reset),
        .exec1   (exec1),
        .dec     (dec),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .address (address),
        .result  (result),
        .flags   (flags)
    );

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period.
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- mips_core_tb.sv
`include "mips_config.svh"

module mips_core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import mips_pkg::*;

    localparam int NUM_INSTR = 60;
    localparam int TIMEOUT_CYCLES = 3 * NUM_INSTR + 16 + 40;
    localparam int K_ALU = 0;
    localparam int K_CTRL = 1;
    localparam int K_LUI = 2;
    localparam int K_ORI = 3;
    localparam int K_JREG = 4;

    logic        clk;
    logic        reset;
    logic [31:0] instr_data;
    logic [31:0] address;
    wb_t         wb;
    logic        halted;
    logic [31:0] prog [NUM_INSTR];
    int          kind [NUM_INSTR];
    logic [31:0] exp_fetch [$];
    wb_t         exp_writes [$];
    int          cycles = 0;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    mips_core dut (
        .clk        (clk),
        .reset      (reset),
        .instr_data (instr_data),
        .address    (address),
        .wb         (wb),
        .halted     (halted)
    );

    task automatic stop_on_error(string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_equal(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("FAIL %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    function automatic logic [31:0] instr_addr(int idx);
        return `MIPS_RESET_VECTOR + 32'(idx) * 32'd4;
    endfunction

    function automatic logic [31:0] fetch_word(logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - `MIPS_RESET_VECTOR;
        if (addr >= `MIPS_RESET_VECTOR && offset < 4 * NUM_INSTR) begin
            return prog[offset >> 2];
        end else begin
            return 32'd0;  // NOP outside the program.
        end
    endfunction

    // Forward target that never skips into the middle of a JR setup.
    function automatic int pick_target(int lo);
        int t;
        t = $urandom_range(NUM_INSTR - 2, lo);
        while (kind[t] == K_ORI || kind[t] == K_JREG) begin
            t++;
        end
        return t;
    endfunction

    function automatic logic [31:0] alu_word();
        logic [4:0]  s;
        logic [4:0]  u;
        logic [4:0]  d;
        logic [15:0] imm;
        s = $urandom_range(15);
        u = $urandom_range(15);
        d = $urandom_range(15);
        imm = $urandom_range(16'hFFFF);
        case ($urandom_range(8))
            0:       return {6'h00, s, u, d, 5'd0, 6'h21};
            1:       return {6'h00, s, u, d, 5'd0, 6'h23};
            2:       return {6'h00, s, u, d, 5'd0, 6'h24};
            3:       return {6'h00, s, u, d, 5'd0, 6'h25};
            4:       return {6'h00, s, u, d, 5'd0, 6'h2A};
            5:       return {6'h09, s, d, imm};
            6:       return {6'h0C, s, d, imm};
            7:       return {6'h0D, s, d, imm};
            default: return {6'h0F, 5'd0, d, imm};
        endcase
    endfunction

    function automatic logic [31:0] control_word(int at, int t);
        logic [4:0]  s;
        logic [4:0]  u;
        logic [15:0] off;
        logic [31:0] ta;
        s = $urandom_range(15);
        u = $urandom_range(15);
        off = 16'(t - at - 1);  // Relative to the delay slot.
        ta = instr_addr(t);
        case ($urandom_range(9))
            0:       return {6'h04, s, u, off};
            1:       return {6'h05, s, u, off};
            2:       return {6'h06, s, 5'd0, off};
            3:       return {6'h07, s, 5'd0, off};
            4:       return {6'h01, s, 5'h00, off};
            5:       return {6'h01, s, 5'h01, off};
            6:       return {6'h01, s, 5'h10, off};
            7:       return {6'h01, s, 5'h11, off};
            8:       return {6'h02, ta[27:2]};
            default: return {6'h03, ta[27:2]};
        endcase
    endfunction

    task automatic build_program();
        int          i;
        logic [31:0] target_addr;
        foreach (kind[k]) begin
            kind[k] = K_ALU;
        end
        i = 0;
        while (i < NUM_INSTR - 2) begin
            if ($urandom_range(9) < 2 && i <= NUM_INSTR - 6) begin
                kind[i] = K_LUI;  // LUI, ORI, JR or JALR, slot.
                kind[i + 1] = K_ORI;
                kind[i + 2] = K_JREG;
                i += 4;
            end else if ($urandom_range(9) < 4 && i <= NUM_INSTR - 4) begin
                kind[i] = K_CTRL;
                i += 2;
            end else begin
                i++;
            end
        end
        for (i = 0; i < NUM_INSTR - 2; i++) begin
            case (kind[i])
                K_CTRL: prog[i] = control_word(i, pick_target(i + 2));
                K_LUI: begin
                    target_addr = instr_addr(pick_target(i + 4));
                    prog[i] = {6'h0F, 5'd0, 5'd30, target_addr[31:16]};
                    prog[i + 1] = {6'h0D, 5'd30, 5'd30, target_addr[15:0]};
                    if ($urandom_range(1) == 0) begin
                        prog[i + 2] = {6'h00, 5'd30, 15'd0, 6'h08};
                    end else begin
                        prog[i + 2] = {6'h00, 5'd30, 5'd0, 5'($urandom_range(15, 1)),
                                       5'd0, 6'h09};
                    end
                end
                K_ALU:   prog[i] = alu_word();
                default: ;
            endcase
        end
        prog[NUM_INSTR - 2] = {6'h00, 5'd0, 15'd0, 6'h08};  // JR r0 halts.
        prog[NUM_INSTR - 1] = 32'd0;
    endtask

    task automatic run_model();
        logic [31:0] regs_m [32];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] target;
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] simm;
        logic [4:0]  wr;
        logic        we;
        logic        taken;
        int          steps;
        foreach (regs_m[k]) begin
            regs_m[k] = 32'd0;
        end
        pc = `MIPS_RESET_VECTOR;
        npc = pc + 32'd4;
        steps = 0;
        while (pc != 32'd0 && steps < 4 * NUM_INSTR) begin
            word = fetch_word(pc);
            a = regs_m[word[25:21]];
            b = regs_m[word[20:16]];
            simm = {{16{word[15]}}, word[15:0]};
            target = npc + (simm << 2);
            res = npc + 32'd4;  // Link value.
            wr = word[20:16];
            we = word[31:26] inside {6'h09, 6'h0C, 6'h0D, 6'h0F};
            taken = 1'b0;
            case (word[31:26])
                6'h00: begin
                    wr = word[15:11];
                    we = 1'b1;
                    case (word[5:0])
                        6'h21: res = a + b;
                        6'h23: res = a - b;
                        6'h24: res = a & b;
                        6'h25: res = a | b;
                        6'h2A: res = {31'd0, $signed(a) < $signed(b)};
                        6'h08, 6'h09: begin
                            we = word[0];  // JALR links, JR does not.
                            taken = 1'b1;
                            target = a;
                        end
                        default: we = 1'b0;
                    endcase
                end
                6'h01: begin
                    wr = `MIPS_LINK_REG;
                    we = word[20];
                    taken = word[16] ? !a[31] : a[31];
                end
                6'h02, 6'h03: begin
                    wr = `MIPS_LINK_REG;
                    we = word[26];
                    taken = 1'b1;
                    target = {npc[31:28], word[25:0], 2'b00};
                end
                6'h04:   taken = (a == b);
                6'h05:   taken = (a != b);
                6'h06:   taken = a[31] || (a == 32'd0);
                6'h07:   taken = !a[31] && (a != 32'd0);
                6'h09:   res = a + simm;
                6'h0C:   res = a & {16'd0, word[15:0]};
                6'h0D:   res = a | {16'd0, word[15:0]};
                6'h0F:   res = {word[15:0], 16'd0};
                default: ;
            endcase
            if (we) begin
                exp_writes.push_back('{we: 1'b1, addr: wr, data: res});
                if (wr != 5'd0) begin
                    regs_m[wr] = res;
                end
            end
            pc = npc;
            npc = taken ? target : npc + 32'd4;
            exp_fetch.push_back(pc);
            steps++;
        end
    endtask

    always @(negedge clk) begin
        instr_data <= fetch_word(address);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("Timeout: the run did not finish in %0d cycles.",
                                    TIMEOUT_CYCLES));
        end
    end

    initial begin
        logic [31:0] last_address;
        int          gap;
        bit          first_change;
        wb_t         exp_wr;
        instr_data = 32'd0;
        void'($urandom(57));
        build_program();
        run_model();
        repeat (16) begin
            @(negedge clk);
            check_equal("reset address", `MIPS_RESET_VECTOR, address);
            check_equal("reset write enable", 32'd0, 32'(wb.we));
            check_equal("reset halted", 32'd0, 32'(halted));
        end
        last_address = `MIPS_RESET_VECTOR;
        gap = 0;
        first_change = 1'b1;
        do begin
            @(negedge clk);
            gap++;
            if (address !== last_address) begin
                if (!first_change) begin
                    check_equal("fetch spacing", 32'd3, 32'(gap));
                end
                first_change = 1'b0;
                gap = 0;
                last_address = address;
                if (exp_fetch.size() == 0) begin
                    stop_on_error("The fetch address moved after the model's program ended.");
                end else begin
                    check_equal("fetch address", exp_fetch.pop_front(), address);
                end
            end
            if (wb.we === 1'b1) begin
                if (exp_writes.size() == 0) begin
                    stop_on_error("The core wrote a register the model did not expect.");
                end else begin
                    exp_wr = exp_writes.pop_front();
                    check_equal("write register", 32'(exp_wr.addr), 32'(wb.addr));
                    check_equal("write data", exp_wr.data, wb.data);
                end
            end
        end while (halted !== 1'b1);
        if (exp_fetch.size() != 0 || exp_writes.size() != 0) begin
            stop_on_error("The core halted before finishing the model's program.");
        end
        while (cycles < TIMEOUT_CYCLES - 2) begin
            @(negedge clk);
            check_equal("halt address", 32'd0, address);
            check_equal("halt flag", 32'd1, 32'(halted));
            check_equal("halt write enable", 32'd0, 32'(wb.we));
        end
        $display("All tests passed");
        $finish;
    end

endmodule

//--- all.f
+incdir+.
mips_pkg.sv
cycle_control.sv
program_counter.sv
instr_decoder.sv
register_file.sv
alu.sv
mips_core.sv
tb_clock_gen.sv
mips_core_tb.sv

//--- Bender.yml
package:
  name: mips_core

sources:
  - include_dirs:
      - .
    files:
      - mips_pkg.sv
      - cycle_control.sv
      - program_counter.sv
      - instr_decoder.sv
      - register_file.sv
      - alu.sv
      - mips_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - mips_core_tb.sv
